// ==== filelist.f ====
verilog/sprite_pkg.sv
verilog/sprite_attr_ram.sv
verilog/sprite_scanner.sv
verilog/line_buffer.sv
verilog/sprite_line_engine.sv
dv/sprite_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the sprite engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module sprite_tb -f filelist.f -o sprite_sim \
  > build.log 2>&1 \
  && ./obj_dir/sprite_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

// ==== dv/sprite_tb.sv ====
`timescale 1ns/1ns

module sprite_tb
  import sprite_pkg::*;
();

  localparam int LINES_RUN      = 8;
  localparam int TIMEOUT_CYCLES = LINES_RUN * SPRITE_COUNT * 200 + 4000;
  localparam pen_t CLEAR_PEN    = '{colour: 4'd0, pixel: TRANSPARENT_PEN};

  logic clk_sys, reset, line_start, busy, line_done, rom_req, pix_rd, pix_valid;
  logic [LINE_W-1:0] line, pix_x;
  logic [15:0] host_rdata;
  logic [ROM_ADDR_W-1:0] rom_addr;
  host_req_t host;
  rom_rsp_t rom;
  pen_t pix_out;

  // reference model
  logic [15:0] attr_model [ATTR_WORDS];
  pen_t exp_render [LINE_PIXELS];
  pen_t exp_show [LINE_PIXELS];
  bit fetch_ok [1 << ROM_ADDR_W];
  logic [ROM_ADDR_W-1:0] fetch_list [$];
  logic [LINE_W-1:0] line_list [LINES_RUN];
  logic addr_known;

  // expectation driven with each read, delayed to the response cycle
  logic rd_chk, hchk, rd_q, chk_q, hchk_q;
  pen_t exp_pen, exp_q;
  logic [LINE_W-1:0] x_q;
  logic [15:0] hexp, hexp_q;

  int err_value = 0;
  int err_other = 0;
  int cycle_count = 0;

  sprite_line_engine uut (.*);

  initial clk_sys = 1'b0;
  always #50 clk_sys = ~clk_sys;

  assign addr_known = fetch_ok[rom_addr];

  always @(posedge clk_sys) begin
    rd_q        <= pix_rd;
    chk_q       <= rd_chk;
    exp_q       <= exp_pen;
    x_q         <= pix_x;
    hchk_q      <= hchk;
    hexp_q      <= hexp;
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] got);
    err_value++;
    $display("CHECK FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
  endtask

  task automatic report_violation(input string what);
    err_other++;
    $display("t=%0t %s", $time, what);
  endtask

  // ==========================================================
  // rom model and expected line
  // ==========================================================

  function automatic logic [31:0] rom_hash(input logic [ROM_ADDR_W-1:0] a);
    logic [31:0] h;
    h = 32'(a) * 32'h9E37_79B1;
    return h ^ (h >> 13);
  endfunction

  // low half-word holds pixels 0..3, msb nibble first
  function automatic logic [3:0] nibble_at(input logic [31:0] word, input int k);
    int sh;
    sh = (k < 4) ? 12 - 4 * k : 28 - 4 * (k - 4);
    return word[sh +: 4];
  endfunction

  task automatic build_line(input logic [LINE_W-1:0] ln);
    logic [15:0] wy, wx, wt, wc;
    logic [ROW_W-1:0] row;
    logic [ROM_ADDR_W-1:0] addr;
    logic [LINE_W-1:0] px;
    logic [3:0] pix;
    logic half;
    int dy;
    foreach (exp_render[i]) exp_render[i] = CLEAR_PEN;
    foreach (fetch_list[i]) fetch_ok[fetch_list[i]] = 1'b0;
    fetch_list.delete();
    for (int s = 0; s < SPRITE_COUNT; s++) begin
      wy = attr_model[4 * s];
      wx = attr_model[4 * s + 1];
      wt = attr_model[4 * s + 2];
      wc = attr_model[4 * s + 3];
      dy = int'(ln) - int'(wy[LINE_W-1:0]);
      if (dy >= 0 && dy < SPRITE_SIZE && wx[7:0] != X_DISABLE) begin
        row = wt[15] ? ROW_W'(15 - dy) : ROW_W'(dy);
        for (int i = 0; i < SPRITE_SIZE; i++) begin
          half = wt[14] ^ (i >= 8);
          addr = {wt[TILE_W-1:0], half, row};
          if (!fetch_ok[addr]) begin
            fetch_ok[addr] = 1'b1;
            fetch_list.push_back(addr);
          end
          pix = nibble_at(rom_hash(addr), wt[14] ? 7 - i % 8 : i % 8);
          px  = LINE_W'(int'(wx[LINE_W-1:0]) + i);
          // later records simply overwrite
          if (pix != TRANSPARENT_PEN) exp_render[px] = '{colour: wc[15:12], pixel: pix};
        end
      end
    end
  endtask

  // ==========================================================
  // stimulus
  // ==========================================================

  // write, then read the same word back on the next cycle
  task automatic write_word(input int a, input logic [15:0] d);
    @(negedge clk_sys);
    host = '{we: 1'b1, addr: ATTR_ADDR_W'(a), data: d};
    attr_model[a] = d;
    @(negedge clk_sys);
    host.we = 1'b0;
    hchk    = 1'b1;
    hexp    = d;
    @(negedge clk_sys);
    hchk = 1'b0;
  endtask

  task automatic load_table();
    logic [15:0] rec [4];
    int idx;
    for (int s = 0; s < SPRITE_COUNT; s++) begin
      idx    = int'($urandom % LINES_RUN);
      rec[0] = {7'd0, LINE_W'(int'(line_list[idx]) - int'($urandom % 20))};
      rec[1] = 16'($urandom % LINE_PIXELS);
      if ($urandom % 6 == 0) rec[1][7:0] = X_DISABLE;
      rec[2] = 16'($urandom);
      rec[3] = 16'($urandom);
      // overlapping pair on line 40, wrapping sprite on line 48
      if (s == 20) rec = '{16'd37, 16'd100, 16'h4123, 16'h5000};
      if (s == 21) rec = '{16'd32, 16'd104, 16'h8456, 16'hA000};
      if (s == 22) rec = '{16'd43, 16'd505, 16'hC789, 16'h3000};
      for (int w = 0; w < WORDS_PER_SPRITE; w++) write_word(4 * s + w, rec[w]);
    end
  endtask

  task automatic read_front(input bit use_model, input bit check);
    for (int x = 0; x < LINE_PIXELS; x++) begin
      @(negedge clk_sys);
      pix_rd  = 1'b1;
      pix_x   = LINE_W'(x);
      rd_chk  = check;
      exp_pen = use_model ? exp_show[x] : CLEAR_PEN;
    end
    @(negedge clk_sys);
    pix_rd = 1'b0;
    rd_chk = 1'b0;
  endtask

  initial begin : rom_responder
    rom = '{ack: 1'b0, data: 32'd0};
    forever begin
      @(negedge clk_sys);
      if (rom_req && !rom.ack) begin
        repeat (int'($urandom % 6)) @(negedge clk_sys);
        rom.data = rom_hash(rom_addr);
        rom.ack  = 1'b1;
        while (rom_req) @(negedge clk_sys);
        repeat (int'($urandom % 4)) @(negedge clk_sys);
        rom.ack = 1'b0;
      end
    end
  end

  initial begin : main_flow
    void'($urandom(50675));
    reset      = 1'b1;
    host       = '{we: 1'b0, addr: '0, data: 16'd0};
    line_start = 1'b0;
    line       = '0;
    pix_rd     = 1'b0;
    pix_x      = '0;
    rd_chk     = 1'b0;
    exp_pen    = CLEAR_PEN;
    hchk       = 1'b0;
    hexp       = 16'd0;
    line_list  = '{9'd40, 9'd48, 9'd56, 9'd63, 9'd200, 9'd201, 9'd505, 9'd511};
    repeat (2) @(negedge clk_sys);
    reset = 1'b0;
    // front bank powers up unknown
    read_front(1'b0, 1'b0);
    load_table();
    // each pass shows the line rendered on the pass before
    for (int n = 0; n <= LINES_RUN; n++) begin
      exp_show = exp_render;
      build_line((n < LINES_RUN) ? line_list[n] : LINE_W'(0));
      @(negedge clk_sys);
      line_start = 1'b1;
      line       = (n < LINES_RUN) ? line_list[n] : LINE_W'(0);
      @(negedge clk_sys);
      line_start = 1'b0;
      while (!line_done) @(negedge clk_sys);
      read_front(1'b1, n > 0);
      read_front(1'b0, 1'b1);
    end
    repeat (3) @(negedge clk_sys);
    $display("errors: %0d value mismatches, %0d protocol violations", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // ==========================================================
  // checks, sampled mid-cycle
  // ==========================================================

  reset_idle: assert property (@(negedge clk_sys)
    reset |-> !busy && !line_done && !rom_req && !pix_valid)
    else report_violation("outputs not idle during reset");

  host_readback: assert property (@(negedge clk_sys) disable iff (reset)
    hchk_q |-> host_rdata == hexp_q)
    else report_mismatch("host_rdata", hexp_q, host_rdata);

  pix_valid_align: assert property (@(negedge clk_sys) disable iff (reset)
    pix_valid == rd_q)
    else report_violation("pix_valid not exactly one cycle after pix_rd");

  pix_match: assert property (@(negedge clk_sys) disable iff (reset)
    rd_q && chk_q |-> pix_out == exp_q)
    else report_mismatch($sformatf("pix_out[%0d]", x_q), 16'(exp_q), 16'(pix_out));

  req_waits_ack: assert property (@(negedge clk_sys) disable iff (reset)
    $rose(rom_req) |-> !rom.ack)
    else report_violation("rom_req rose while ack was still high");

  req_drops_on_ack: assert property (@(negedge clk_sys) disable iff (reset)
    $fell(rom_req) |-> rom.ack)
    else report_violation("rom_req dropped before ack");

  addr_hold: assert property (@(negedge clk_sys) disable iff (reset)
    rom_req && $past(rom_req) |-> $stable(rom_addr))
    else report_violation("rom_addr moved during a request");

  fetch_known: assert property (@(negedge clk_sys) disable iff (reset)
    $rose(rom_req) |-> addr_known)
    else report_violation("rom fetch of an address no hit record needs");

endmodule

// ==== verilog/sprite_line_engine.sv ====
`timescale 1ns/1ns

module sprite_line_engine
  import sprite_pkg::*;
(
  input  logic                  clk_sys,
  input  logic                  reset,
  input  host_req_t             host,
  output logic [15:0]           host_rdata,
  input  logic                  line_start,
  input  logic [LINE_W-1:0]     line,
  output logic                  busy,
  output logic                  line_done,
  output logic                  rom_req,
  output logic [ROM_ADDR_W-1:0] rom_addr,
  input  rom_rsp_t              rom,
  input  logic                  pix_rd,
  input  logic [LINE_W-1:0]     pix_x,
  output logic                  pix_valid,
  output pen_t                  pix_out
);

  logic [ATTR_ADDR_W-1:0] scan_addr;
  logic [15:0]            scan_data;
  logic                   wr_en;
  logic [LINE_W-1:0]      wr_x;
  pen_t                   wr_pen;
  logic                   line_accept;

  // buffers swap only on a line the scanner takes
  assign line_accept = line_start && !busy;

  sprite_attr_ram u_attr_ram (
    .clk_sys    (clk_sys),
    .host       (host),
    .host_rdata (host_rdata),
    .scan_addr  (scan_addr),
    .scan_data  (scan_data)
  );

  sprite_scanner u_scanner (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .line_start (line_start),
    .line       (line),
    .busy       (busy),
    .line_done  (line_done),
    .scan_addr  (scan_addr),
    .scan_data  (scan_data),
    .rom_req    (rom_req),
    .rom_addr   (rom_addr),
    .rom        (rom),
    .wr_en      (wr_en),
    .wr_x       (wr_x),
    .wr_pen     (wr_pen)
  );

  line_buffer u_line_buffer (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .line_start (line_accept),
    .wr_en      (wr_en),
    .wr_x       (wr_x),
    .wr_pen     (wr_pen),
    .pix_rd     (pix_rd),
    .pix_x      (pix_x),
    .pix_valid  (pix_valid),
    .pix_out    (pix_out)
  );

endmodule

// ==== verilog/line_buffer.sv ====
`timescale 1ns/1ns

module line_buffer
  import sprite_pkg::*;
(
  input  logic              clk_sys,
  input  logic              reset,
  input  logic              line_start,
  input  logic              wr_en,
  input  logic [LINE_W-1:0] wr_x,
  input  pen_t              wr_pen,
  input  logic              pix_rd,
  input  logic [LINE_W-1:0] pix_x,
  output logic              pix_valid,
  output pen_t              pix_out
);

  // bank_sel selects the back bank
  // the other bank is shown
  logic bank_sel;
  logic rd_bank;
  pen_t rd_data [2];

  logic [1:0] bank_wr;
  logic [1:0] bank_clr;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      bank_sel  <= 1'b0;
      pix_valid <= 1'b0;
    end else begin
      if (line_start) begin
        bank_sel <= ~bank_sel;
      end
      pix_valid <= pix_rd;
    end
  end

  // front bank latched per read since a swap may follow
  always_ff @(posedge clk_sys) begin
    if (pix_rd) begin
      rd_bank <= ~bank_sel;
    end
  end

  for (genvar b = 0; b < 2; b++) begin : g_bank
    pen_t mem [LINE_PIXELS];

    // only opaque pens reach the back bank
    assign bank_wr[b]  = wr_en && (bank_sel == 1'(b)) && (wr_pen.pixel != TRANSPARENT_PEN);
    assign bank_clr[b] = pix_rd && (bank_sel != 1'(b));

    always_ff @(posedge clk_sys) begin
      if (bank_wr[b]) begin
        mem[wr_x] <= wr_pen;
      end else if (bank_clr[b]) begin
        mem[pix_x] <= '{colour: 4'd0, pixel: TRANSPARENT_PEN};
      end
      rd_data[b] <= mem[pix_x];
    end
  end

  assign pix_out = rd_data[rd_bank];

  // a pen written as the banks swap would land in the line being shown
  no_wr_on_swap: assert property (
    @(posedge clk_sys) disable iff (reset)
    !(line_start && wr_en)
  ) else $error("pen write in the cycle the banks swap");

endmodule

// ==== verilog/sprite_scanner.sv ====
`timescale 1ns/1ns

module sprite_scanner
  import sprite_pkg::*;
(
  input  logic                   clk_sys,
  input  logic                   reset,
  input  logic                   line_start,
  input  logic [LINE_W-1:0]      line,
  output logic                   busy,
  output logic                   line_done,
  output logic [ATTR_ADDR_W-1:0] scan_addr,
  input  logic [15:0]            scan_data,
  output logic                   rom_req,
  output logic [ROM_ADDR_W-1:0]  rom_addr,
  input  rom_rsp_t               rom,
  output logic                   wr_en,
  output logic [LINE_W-1:0]      wr_x,
  output pen_t                   wr_pen
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_Y_WAIT,
    S_Y,
    S_X,
    S_TILE,
    S_COLOUR,
    S_REQ,
    S_ACK,
    S_DRAW,
    S_NEXT
  } state_t;

  state_t state;

  logic [SPRITE_IDX_W-1:0] idx;
  logic [LINE_W-1:0]       cur_line;

  // per-record working copy
  logic [LINE_W-1:0] x_pos;
  logic [ROW_W-1:0]  row;
  logic [TILE_W-1:0] tile;
  logic              flip_x;
  logic [3:0]        colour;
  logic [31:0]       rom_word;
  logic [3:0]        pix_ofs;

  // ==========================================================
  // hit test on the y word
  // ==========================================================

  logic [LINE_W:0] y_top;
  logic [LINE_W:0] y_end;
  logic [LINE_W:0] line_ext;
  logic            y_hit;
  logic [LINE_W-1:0] y_delta;

  assign y_top    = {1'b0, scan_data[LINE_W-1:0]};
  assign y_end    = y_top + (LINE_W+1)'(SPRITE_SIZE);
  assign line_ext = {1'b0, cur_line};
  assign y_hit    = (line_ext >= y_top) && (line_ext < y_end);
  assign y_delta  = cur_line - scan_data[LINE_W-1:0];

  // pixel under the current offset, reversed for flip_x
  logic [3:0] cur_pixel;

  assign cur_pixel = pixel_of(rom_word, {3{flip_x}} ^ pix_ofs[2:0]);

  // ==========================================================
  // record scan FSM
  // ==========================================================

  always_ff @(posedge clk_sys) begin
    wr_en     <= 1'b0;
    line_done <= 1'b0;
    if (reset) begin
      state   <= S_IDLE;
      busy    <= 1'b0;
      rom_req <= 1'b0;
      idx     <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (line_start) begin
            busy      <= 1'b1;
            cur_line  <= line;
            idx       <= '0;
            scan_addr <= {SPRITE_IDX_W'(0), WORD_Y};
            state     <= S_Y_WAIT;
          end
        end
        // words are streamed, each state queues the next address
        S_Y_WAIT: begin
          scan_addr <= {idx, WORD_X};
          state     <= S_Y;
        end
        S_Y: begin
          scan_addr <= {idx, WORD_TILE};
          row       <= y_delta[ROW_W-1:0];
          state     <= y_hit ? S_X : S_NEXT;
        end
        S_X: begin
          scan_addr <= {idx, WORD_COLOUR};
          x_pos     <= scan_data[LINE_W-1:0];
          state     <= (scan_data[7:0] == X_DISABLE) ? S_NEXT : S_TILE;
        end
        S_TILE: begin
          tile   <= scan_data[TILE_W-1:0];
          flip_x <= scan_data[14];
          // flip_y mirrors the row inside the tile
          row    <= row ^ {ROW_W{scan_data[15]}};
          state  <= S_COLOUR;
        end
        S_COLOUR: begin
          colour  <= scan_data[15:12];
          pix_ofs <= '0;
          state   <= S_REQ;
        end
        // wait for ack low from the last fetch before a new request
        S_REQ: begin
          if (!rom.ack) begin
            rom_req  <= 1'b1;
            rom_addr <= {tile, flip_x ^ pix_ofs[3], row};
            state    <= S_ACK;
          end
        end
        S_ACK: begin
          if (rom.ack) begin
            rom_word <= rom.data;
            rom_req  <= 1'b0;
            state    <= S_DRAW;
          end
        end
        S_DRAW: begin
          wr_en       <= (cur_pixel != TRANSPARENT_PEN);
          wr_x        <= x_pos + LINE_W'(pix_ofs);
          wr_pen      <= '{colour: colour, pixel: cur_pixel};
          pix_ofs     <= pix_ofs + 4'd1;
          if (pix_ofs[2:0] == 3'd7) begin
            state <= pix_ofs[3] ? S_NEXT : S_REQ;
          end
        end
        S_NEXT: begin
          if (idx == SPRITE_IDX_W'(SPRITE_COUNT - 1)) begin
            line_done <= 1'b1;
            busy      <= 1'b0;
            state     <= S_IDLE;
          end else begin
            idx       <= idx + 1'b1;
            scan_addr <= {idx + 1'b1, WORD_Y};
            state     <= S_Y_WAIT;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ==========================================================
  // checks
  // ==========================================================

  // address held for the whole request phase
  rom_addr_stable: assert property (
    @(posedge clk_sys) disable iff (reset)
    rom_req |=> (!rom_req || $stable(rom_addr))
  ) else $error("rom_addr changed while rom_req high");

  pen_opaque: assert property (
    @(posedge clk_sys) disable iff (reset)
    wr_en |-> (wr_pen.pixel != TRANSPARENT_PEN)
  ) else $error("transparent pen written");

  // the host side must wait for line_done
  no_start_busy: assert property (
    @(posedge clk_sys) disable iff (reset)
    !(line_start && busy)
  ) else $error("line_start while busy");

endmodule

// ==== verilog/sprite_attr_ram.sv ====
`timescale 1ns/1ns

module sprite_attr_ram
  import sprite_pkg::*;
(
  input  logic                   clk_sys,
  input  host_req_t              host,
  output logic [15:0]            host_rdata,
  input  logic [ATTR_ADDR_W-1:0] scan_addr,
  output logic [15:0]            scan_data
);

  // sprite records, four words each
  logic [15:0] mem [ATTR_WORDS];

  // host side, write plus registered readback
  always_ff @(posedge clk_sys) begin
    if (host.we) begin
      mem[host.addr] <= host.data;
    end
    host_rdata <= mem[host.addr];
  end

  // scanner side, read only
  always_ff @(posedge clk_sys) begin
    scan_data <= mem[scan_addr];
  end

endmodule

// ==== verilog/sprite_pkg.sv ====
package sprite_pkg;

  // ==========================================================
  // sprite table geometry
  // ==========================================================

  localparam int SPRITE_COUNT     = 32;
  localparam int WORDS_PER_SPRITE = 4;
  localparam int ATTR_ADDR_W      = 7;
  localparam int ATTR_WORDS       = SPRITE_COUNT * WORDS_PER_SPRITE;
  localparam int SPRITE_IDX_W     = $clog2(SPRITE_COUNT);

  // word order inside one record
  localparam logic [1:0] WORD_Y      = 2'd0;
  localparam logic [1:0] WORD_X      = 2'd1;
  localparam logic [1:0] WORD_TILE   = 2'd2;
  localparam logic [1:0] WORD_COLOUR = 2'd3;

  localparam int SPRITE_SIZE = 16;
  localparam int ROW_W       = $clog2(SPRITE_SIZE);
  localparam int TILE_W      = 13;

  // ==========================================================
  // line buffer and rom
  // ==========================================================

  localparam int LINE_W      = 9;
  localparam int LINE_PIXELS = 1 << LINE_W;

  // x low byte of an unused record
  localparam logic [7:0] X_DISABLE = 8'hFF;

  // never written, also the clear value
  localparam logic [3:0] TRANSPARENT_PEN = 4'd15;

  // tile, half select, row
  localparam int ROM_ADDR_W = TILE_W + 1 + ROW_W;

  typedef struct packed {
    logic [3:0] colour;
    logic [3:0] pixel;
  } pen_t;

  typedef struct packed {
    logic                   we;
    logic [ATTR_ADDR_W-1:0] addr;
    logic [15:0]            data;
  } host_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] data;
  } rom_rsp_t;

  // nibble k of a rom word, low half-word first, msb nibble first
  function automatic logic [3:0] pixel_of(input logic [31:0] word, input logic [2:0] k);
    logic [3:0] nib;
    case (k)
      3'd0: nib = word[15:12];
      3'd1: nib = word[11:8];
      3'd2: nib = word[7:4];
      3'd3: nib = word[3:0];
      3'd4: nib = word[31:28];
      3'd5: nib = word[27:24];
      3'd6: nib = word[23:20];
      default: nib = word[19:16];
    endcase
    return nib;
  endfunction

endpackage
